// ==== msx_bus_map.f ====
+incdir+rtl
rtl/msx_bus_pkg.sv
rtl/cpu_clock_enable.sv
rtl/primary_slot.sv
rtl/secondary_slot.sv
rtl/sdram_map.sv
rtl/read_return.sv
rtl/msx_bus_map.sv
dv/tb_msx_bus_map.sv

// ==== Makefile ====
# Verilator simulation of the MSX bus map
TOP := tb_msx_bus_map

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build and run the testbench, fails unless the run passes"
	@echo "  clean  remove the build output"

test:
	verilator --binary -j 0 --top-module $(TOP) -f msx_bus_map.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -F "ALL TESTS PASSED" > /dev/null

clean:
	rm -rf obj_dir

// ==== dv/tb_msx_bus_map.sv ====
// Directed testbench: clock, reset, bus tasks, checker, watchdog and six tests
`default_nettype none
`include "msx_bus_defines.svh"

module tb_msx_bus_map;
	timeunit 1ns;
	timeprecision 100ps;

	import msx_bus_pkg::*;

	localparam int NUM_TESTS	= 6;
	localparam int TEST_BUDGET	= 2000;		// ns per test

	logic			clk42m;
	logic			ff_reset_n;
	cpu_bus_t		cpu;
	spi_wr_t		spi;
	logic			cpu_freeze;
	logic			sdram_busy;
	rd_src_t		sdram_rdata;	// SDRAM controller return
	logic			cpu_enable;
	sdram_req_t		sdram;
	logic	[7:0]	cpu_rdata;
	logic	[31:0]	rng_state;

	msx_bus_map dut0 (
		.clk42m			(clk42m),
		.ff_reset_n		(ff_reset_n),
		.cpu			(cpu),
		.spi			(spi),
		.cpu_freeze		(cpu_freeze),
		.sdram_busy		(sdram_busy),
		.sdram_rdata	(sdram_rdata),
		.cpu_enable		(cpu_enable),
		.sdram			(sdram),
		.cpu_rdata		(cpu_rdata)
	);

	// ------------------------------
	// Clock and watchdog
	// ------------------------------
	initial begin
		clk42m = 1'b0;
		forever #5 clk42m = ~clk42m;	// 10 ns period
	end

	initial begin
		#(NUM_TESTS * TEST_BUDGET);
		$display("Watchdog timeout, the tests did not finish in time");
		$display("SOME TESTS FAILED");
		$fatal(1, "watchdog expired");
	end

	// ------------------------------
	// Helpers
	// ------------------------------
	function automatic logic [31:0] prng_step(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic draw_random(output logic [31:0] value);
		rng_state = prng_step(rng_state);
		value = rng_state;
	endtask

	// Upper SDRAM address 22:13 for a slot and subslot
	function automatic logic [9:0] bank_code(input logic [1:0] slot, input logic [1:0] sub,
			input logic [15:0] a);
		logic [9:0] code;
		case (slot)
			2'd1: code = `MSX_BANK_MEGA1M;
			2'd2: code = `MSX_BANK_MEGA512K;
			2'd0: begin
				case (sub)
					2'd3: code = {`MSX_BANK_LOGO_EXT, a[14:13]};
					2'd2: code = {`MSX_BANK_MUSIC, a[13]};
					2'd1: code = {`MSX_BANK_IOT, a[13]};
					default: code = {`MSX_BANK_MAIN, a[14:13]};
				endcase
			end
			default: begin
				case (sub)
					2'd0: code = `MSX_BANK_MAPPER;
					2'd1: code = {`MSX_BANK_SUB_KANJI, a[14:13]};
					2'd2: code = {`MSX_BANK_NEXTOR, a[15:13]};
					default: code = 10'd0;		// Slot 3-3 is empty
				endcase
			end
		endcase
		return code;
	endfunction

	task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		if (actual !== expected) begin
			$display("** Error at %0t: %s, got %0h, expected %0h", $time, what, actual,
				expected);
			$display("SOME TESTS FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic step();
		@(posedge clk42m);
		#1;		// Drive point
	endtask

	task automatic bus_idle();
		cpu			= '0;
		cpu.mreq_n	= 1'b1;
		cpu.iorq_n	= 1'b1;
		cpu.rd_n	= 1'b1;
		cpu.wr_n	= 1'b1;
	endtask

	// Keep strobes until the third edge, then one idle cycle
	task automatic hold_and_release(input int edges);
		repeat (edges) @(posedge clk42m);
		#1;
		bus_idle();
		step();		// Next read gets a fresh strobe
	endtask

	// ------------------------------
	// Bus tasks
	// ------------------------------
	task automatic io_write(input logic [7:0] port, input logic [7:0] data);
		cpu.addr	= {8'h00, port};
		cpu.wdata	= data;
		cpu.iorq_n	= 1'b0;
		cpu.wr_n	= 1'b0;
		hold_and_release(3);
	endtask

	task automatic mem_write(input logic [15:0] addr, input logic [7:0] data);
		cpu.addr	= addr;
		cpu.wdata	= data;
		cpu.mreq_n	= 1'b0;
		cpu.wr_n	= 1'b0;
		hold_and_release(3);
	endtask

	task automatic io_read(input logic [7:0] port, output logic [7:0] rdata,
			output sdram_req_t req);
		cpu.addr	= {8'h00, port};
		cpu.iorq_n	= 1'b0;
		cpu.rd_n	= 1'b0;
		@(negedge clk42m);
		req = sdram;				// Map output, same cycle
		@(negedge clk42m);
		rdata = cpu_rdata;			// One cycle after the strobe
		hold_and_release(2);
	endtask

	task automatic mem_read(input logic [15:0] addr, output logic [7:0] rdata,
			output sdram_req_t req);
		cpu.addr	= addr;
		cpu.mreq_n	= 1'b0;
		cpu.rd_n	= 1'b0;
		@(negedge clk42m);
		req = sdram;
		@(negedge clk42m);
		rdata = cpu_rdata;
		hold_and_release(2);
	endtask

	// ------------------------------
	// Tests
	// ------------------------------
	// n counts cycles since the divider restarted
	task automatic enable_window(input int cycles, inout int n);
		repeat (cycles) begin
			n++;
			@(negedge clk42m);
			check_eq(32'(cpu_enable), 32'(!sdram_busy && !cpu_freeze && (n % 6 == 0)),
				"cpu_enable");
			step();
		end
	endtask

	task automatic cpu_enable_cadence();
		int n;
		n = 0;						// Called right at reset release
		enable_window(24, n);
		sdram_busy = 1'b1;			// Count runs on, pulses masked
		enable_window(12, n);
		sdram_busy = 1'b0;
		enable_window(11, n);
		cpu_freeze = 1'b1;			// First freeze cycle at count 5
		enable_window(4, n);
		cpu_freeze = 1'b0;
		n = 0;						// Freeze cleared the divider
		enable_window(13, n);
	endtask

	task automatic primary_slot_map();
		logic	[31:0]	r;
		logic	[7:0]	pattern [2];
		logic	[7:0]	rdata;
		logic	[15:0]	a;
		logic	[1:0]	slot;
		sdram_req_t		req;
		draw_random(r);
		pattern[0] = r[7:0];
		pattern[1] = 8'hE4;			// Page n in slot n
		for (int i = 0; i < 2; i++) begin
			io_write(`MSX_PPI_PORT_A, pattern[i]);
			io_read(`MSX_PPI_PORT_A, rdata, req);
			check_eq(32'(rdata), 32'(pattern[i]), "port A8h readback");
			for (int p = 0; p < 4; p++) begin
				draw_random(r);
				a = {2'(p), r[13:0]};
				slot = pattern[i][2*p +: 2];
				mem_read(a, rdata, req);	// Subslot registers still 00h
				check_eq(32'(req.address), 32'({bank_code(slot, 2'd0, a), a[12:0]}),
					"bank for primary slot");
			end
		end
		draw_random(r);
		mem_read({2'b01, r[13:0]}, rdata, req);
		check_eq(32'(req.address[22:13]), 32'(`MSX_BANK_MEGA1M), "slot 1 page 1 bank");
	endtask

	task automatic expanded_slot_map();
		logic	[31:0]	r;
		logic	[7:0]	v;
		logic	[7:0]	rdata;
		logic	[15:0]	a;
		sdram_req_t		req;
		// Slot 0
		io_write(`MSX_PPI_PORT_A, 8'h00);
		draw_random(r);
		v = r[7:0];
		mem_write(`MSX_EXP_SLOT_ADDR, v);
		mem_read(`MSX_EXP_SLOT_ADDR, rdata, req);
		check_eq(32'(rdata), 32'(v ^ 8'hFF), "slot 0 FFFFh readback");
		mem_write(`MSX_EXP_SLOT_ADDR, 8'h08);		// Page 1 in subslot 2
		draw_random(r);
		a = {2'b01, r[13:0]};
		mem_read(a, rdata, req);
		check_eq(32'(req.address), 32'({`MSX_BANK_MUSIC, a[13], a[12:0]}), "MSX-MUSIC bank");
		// Slot 3
		io_write(`MSX_PPI_PORT_A, 8'hFF);
		v = r[23:16];
		mem_write(`MSX_EXP_SLOT_ADDR, v);
		mem_read(`MSX_EXP_SLOT_ADDR, rdata, req);
		check_eq(32'(rdata), 32'(v ^ 8'hFF), "slot 3 FFFFh readback");
		mem_write(`MSX_EXP_SLOT_ADDR, 8'h08);
		draw_random(r);
		a = {2'b01, r[13:0]};
		mem_read(a, rdata, req);
		check_eq(32'(req.address), 32'({bank_code(2'd3, 2'd2, a), a[12:0]}), "Nextor bank");
		// Slot 0 register untouched by slot 3 writes
		io_write(`MSX_PPI_PORT_A, 8'h00);
		mem_read(`MSX_EXP_SLOT_ADDR, rdata, req);
		check_eq(32'(rdata), 32'(8'h08 ^ 8'hFF), "slot 0 register kept");
	endtask

	task automatic read_gating();
		logic	[31:0]	r;
		logic	[7:0]	rdata;
		sdram_req_t		req;
		draw_random(r);
		io_write(`MSX_PPI_PORT_A, 8'h00);
		mem_write(`MSX_EXP_SLOT_ADDR, 8'h00);		// Main ROM everywhere
		mem_read({2'b10, r[13:0]}, rdata, req);
		check_eq(32'(req.rd_n), 32'(1'b1), "main ROM page 2 rd_n");
		mem_read({2'b00, r[13:0]}, rdata, req);
		check_eq(32'(req.rd_n), 32'(1'b0), "main ROM page 0 rd_n");
		io_write(`MSX_PPI_PORT_A, 8'hFF);
		mem_write(`MSX_EXP_SLOT_ADDR, 8'h00);		// Mapper everywhere
		mem_read(`MSX_EXP_SLOT_ADDR, rdata, req);
		check_eq(32'(req.rd_n), 32'(1'b1), "mapper FFFFh rd_n");
		mem_read({3'b110, r[28:16]}, rdata, req);
		check_eq(32'(req.rd_n), 32'(1'b0), "mapper page 3 rd_n");
		io_read(r[7:0], rdata, req);
		check_eq(32'(req.rd_n), 32'(1'b1), "I/O cycle rd_n");
	endtask

	task automatic freeze_passthrough();
		logic [31:0] r;
		cpu_freeze = 1'b1;
		repeat (4) begin
			draw_random(r);
			spi.address	= r[21:0];
			spi.req_n	= r[31];
			draw_random(r);
			spi.wdata	= r[7:0];
			@(negedge clk42m);
			check_eq(32'(sdram.address), 32'({1'b0, spi.address}), "SPI address");
			check_eq(32'(sdram.wdata), 32'(spi.wdata), "SPI data");
			check_eq(32'(sdram.mreq_n), 32'(spi.req_n), "SPI mreq_n");
			check_eq(32'(sdram.wr_n), 32'(spi.req_n), "SPI wr_n");
			step();
		end
		cpu_freeze	= 1'b0;
		spi.req_n	= 1'b1;
	endtask

	task automatic rdata_priority();
		logic	[31:0]	r;
		logic	[7:0]	ppi_val;
		logic	[7:0]	d;
		draw_random(r);
		ppi_val = r[7:0];
		io_write(`MSX_PPI_PORT_A, ppi_val);
		d = ppi_val ^ (r[15:8] | 8'h01);		// Never equal to the PPI byte
		// SDRAM return in the PPI strobe cycle
		cpu.addr			= {8'h00, `MSX_PPI_PORT_A};
		cpu.iorq_n			= 1'b0;
		cpu.rd_n			= 1'b0;
		sdram_rdata.data	= d;
		sdram_rdata.en		= 1'b1;
		step();
		sdram_rdata.en = 1'b0;
		@(negedge clk42m);
		check_eq(32'(cpu_rdata), 32'(d), "SDRAM over PPI");
		hold_and_release(2);
		@(negedge clk42m);
		check_eq(32'(cpu_rdata), 32'(d), "cpu_rdata hold");
		step();
		// SDRAM return on its own
		draw_random(r);
		sdram_rdata.data	= r[7:0];
		sdram_rdata.en		= 1'b1;
		step();
		sdram_rdata.en = 1'b0;
		repeat (3) begin
			@(negedge clk42m);
			check_eq(32'(cpu_rdata), 32'(r[7:0]), "SDRAM return held");
			step();
		end
	endtask

	// ------------------------------
	// Main sequence
	// ------------------------------
	initial begin
		ff_reset_n	= 1'b0;
		cpu_freeze	= 1'b0;
		sdram_busy	= 1'b0;
		spi			= '0;
		spi.req_n	= 1'b1;
		sdram_rdata	= '0;
		rng_state	= 32'h62b9;
		bus_idle();
		repeat (10) @(posedge clk42m);		// Reset for 10 cycles
		#1;
		ff_reset_n = 1'b1;
		cpu_enable_cadence();
		primary_slot_map();
		expanded_slot_map();
		read_gating();
		freeze_passthrough();
		rdata_priority();
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== rtl/msx_bus_map.sv ====
// MSX bus map top: CPU enable, slot registers, SDRAM map and read return
`default_nettype none

module msx_bus_map (
	input	logic						clk42m,
	input	logic						ff_reset_n,
	input	msx_bus_pkg::cpu_bus_t		cpu,
	input	msx_bus_pkg::spi_wr_t		spi,
	input	logic						cpu_freeze,
	input	logic						sdram_busy,
	input	msx_bus_pkg::rd_src_t		sdram_rdata,	// From SDRAM controller
	output	logic						cpu_enable,
	output	msx_bus_pkg::sdram_req_t	sdram,
	output	logic	[7:0]				cpu_rdata
);

	import msx_bus_pkg::*;

	rd_src_t		ppi_rd;
	rd_src_t		exp0_rd;
	rd_src_t		exp3_rd;
	logic	[3:0]	sltsl;			// Primary selects
	logic	[3:0]	sub0;			// Slot 0-x
	logic	[3:0]	sub3;			// Slot 3-x
	slot_sel_t		sel;

	// ------------------------------
	// Bus decode side
	// ------------------------------
	cpu_clock_enable u_cpu_clock_enable (
		.clk42m			(clk42m),
		.ff_reset_n		(ff_reset_n),
		.sdram_busy		(sdram_busy),
		.cpu_freeze		(cpu_freeze),
		.cpu_enable		(cpu_enable)
	);

	primary_slot u_primary_slot (
		.clk42m			(clk42m),
		.ff_reset_n		(ff_reset_n),
		.cpu			(cpu),
		.ppi_rd			(ppi_rd),
		.sltsl			(sltsl)
	);

	secondary_slot exp_slot0 (
		.clk42m			(clk42m),
		.ff_reset_n		(ff_reset_n),
		.cpu			(cpu),
		.sltsl			(sltsl[0]),
		.exp_rd			(exp0_rd),
		.sltsl_ext		(sub0)
	);

	secondary_slot exp_slot3 (
		.clk42m			(clk42m),
		.ff_reset_n		(ff_reset_n),
		.cpu			(cpu),
		.sltsl			(sltsl[3]),
		.exp_rd			(exp3_rd),
		.sltsl_ext		(sub3)
	);

	// ------------------------------
	// Memory map and read return
	// ------------------------------
	// Slots 1 and 2 are not expanded
	assign sel = '{sltsl1: sltsl[1], sltsl2: sltsl[2], sub0: sub0, sub3: sub3};

	sdram_map u_sdram_map (
		.cpu_freeze		(cpu_freeze),
		.cpu			(cpu),
		.spi			(spi),
		.sel			(sel),
		.sdram			(sdram)
	);

	read_return u_read_return (
		.clk42m			(clk42m),
		.ff_reset_n		(ff_reset_n),
		.sdram_rdata	(sdram_rdata),
		.exp0_rd		(exp0_rd),
		.exp3_rd		(exp3_rd),
		.ppi_rd			(ppi_rd),
		.cpu_rdata		(cpu_rdata)
	);

endmodule

`default_nettype wire

// ==== rtl/read_return.sv ====
// Read data return register with fixed source priority
`default_nettype none

module read_return (
	input	logic					clk42m,
	input	logic					ff_reset_n,
	input	msx_bus_pkg::rd_src_t	sdram_rdata,	// Highest priority
	input	msx_bus_pkg::rd_src_t	exp0_rd,
	input	msx_bus_pkg::rd_src_t	exp3_rd,
	input	msx_bus_pkg::rd_src_t	ppi_rd,			// Lowest priority
	output	logic	[7:0]			cpu_rdata
);

	import msx_bus_pkg::*;

	rd_src_t		w_pick;			// Winning source this cycle
	logic	[7:0]	ff_rdata;

	// ------------------------------
	// Source select
	// ------------------------------
	always_comb begin
		if (sdram_rdata.en) begin
			w_pick = sdram_rdata;
		end
		else if (exp0_rd.en) begin
			w_pick = exp0_rd;
		end
		else if (exp3_rd.en) begin
			w_pick = exp3_rd;
		end
		else begin
			w_pick = ppi_rd;		// en may be low, then hold
		end
	end

	always_ff @(posedge clk42m) begin
		if (!ff_reset_n) begin
			ff_rdata <= 8'h00;
		end
		else if (w_pick.en) begin
			ff_rdata <= w_pick.data;	// Valid one cycle after strobe
		end
	end

	assign cpu_rdata = ff_rdata;

endmodule

`default_nettype wire

// ==== rtl/sdram_map.sv ====
// SDRAM memory map: slot to bank translation, read/write gating, SPI updater override
`default_nettype none
`include "msx_bus_defines.svh"

module sdram_map (
	input	logic						cpu_freeze,	// SPI updater owns the bus
	input	msx_bus_pkg::cpu_bus_t		cpu,
	input	msx_bus_pkg::spi_wr_t		spi,
	input	msx_bus_pkg::slot_sel_t		sel,
	output	msx_bus_pkg::sdram_req_t	sdram
);

	logic	[9:0]	w_upper;		// SDRAM address 22:13
	logic			w_rd_win;		// CPU read allowed in this region
	logic			w_page1;
	logic			w_page12;
	logic			w_page01;
	logic			w_not_ffff;
	logic	[1:0]	w_bank2;		// A14:A13

	// ------------------------------
	// Page windows
	// ------------------------------
	assign w_page1		= (cpu.addr.mem.page == 2'b01);
	assign w_page12		= cpu.addr.mem.page[1] ^ cpu.addr.mem.page[0];	// 4000h-BFFFh
	assign w_page01		= !cpu.addr.mem.page[1];						// 0000h-7FFFh
	assign w_not_ffff	= (cpu.addr != `MSX_EXP_SLOT_ADDR);	// Keep FFFFh out of RAM reads
	assign w_bank2		= {cpu.addr.mem.page[0], cpu.addr.mem.bank13};

	// ------------------------------
	// Region priority
	// ------------------------------
	always_comb begin
		w_upper		= 10'd0;		// 3-3 and empty slots
		w_rd_win	= 1'b0;
		if (sel.sub3[0]) begin							// Mapper RAM
			w_upper		= `MSX_BANK_MAPPER;
			w_rd_win	= w_not_ffff;
		end
		else if (sel.sltsl1) begin						// MegaROM 1 MB
			w_upper		= `MSX_BANK_MEGA1M;
			w_rd_win	= w_page12;
		end
		else if (sel.sltsl2) begin						// MegaROM 512 KB
			w_upper		= `MSX_BANK_MEGA512K;
			w_rd_win	= w_page12;
		end
		else if (sel.sub0[3]) begin						// Logo, extended BASIC
			w_upper		= {`MSX_BANK_LOGO_EXT, w_bank2};
			w_rd_win	= w_page12;
		end
		else if (sel.sub0[2]) begin						// MSX-MUSIC
			w_upper		= {`MSX_BANK_MUSIC, cpu.addr.mem.bank13};
			w_rd_win	= w_page1;
		end
		else if (sel.sub0[1]) begin						// IoT-BASIC
			w_upper		= {`MSX_BANK_IOT, cpu.addr.mem.bank13};
			w_rd_win	= w_page1;
		end
		else if (sel.sub3[1]) begin						// Sub-ROM, Kanji BASIC
			w_upper		= {`MSX_BANK_SUB_KANJI, w_bank2};
			w_rd_win	= w_page01;
		end
		else if (sel.sub0[0]) begin						// Main ROM
			w_upper		= {`MSX_BANK_MAIN, w_bank2};
			w_rd_win	= w_page01;
		end
		else if (sel.sub3[2]) begin						// Nextor, 64 KB
			w_upper		= {`MSX_BANK_NEXTOR, cpu.addr.mem.page, cpu.addr.mem.bank13};
			w_rd_win	= w_page12;
		end
	end

	// ------------------------------
	// Request out
	// ------------------------------
	always_comb begin
		if (cpu_freeze) begin
			// Updater writes straight through
			sdram.address	= {{(`MSX_SDRAM_AW - `MSX_SPI_AW){1'b0}}, spi.address};
			sdram.wdata		= spi.wdata;
			sdram.mreq_n	= spi.req_n;
			sdram.wr_n		= spi.req_n;
		end
		else begin
			sdram.address	= {w_upper, cpu.addr.mem.offset};
			sdram.wdata		= cpu.wdata;
			sdram.mreq_n	= cpu.mreq_n;
			sdram.wr_n		= sel.sub3[0] ? cpu.wr_n : 1'b1;	// RAM only in 3-0
		end
		// I/O cycles never read memory
		sdram.rd_n = (cpu.iorq_n && w_rd_win) ? cpu.rd_n : 1'b1;
	end

endmodule

`default_nettype wire

// ==== rtl/secondary_slot.sv ====
// Expanded slot register at FFFFh with inverted readback and four subslot selects
`default_nettype none
`include "msx_bus_defines.svh"

module secondary_slot (
	input	logic					clk42m,
	input	logic					ff_reset_n,
	input	msx_bus_pkg::cpu_bus_t	cpu,
	input	logic					sltsl,		// Primary select of this slot
	output	msx_bus_pkg::rd_src_t	exp_rd,		// Readback, inverted
	output	logic	[3:0]			sltsl_ext	// Subslot selects
);

	logic	[7:0]	ff_ext;			// Subslot per page, page 0 at bit 0
	logic			ff_rd_hit_d;
	logic			w_hit;			// FFFFh inside this slot
	logic			w_rd_hit;
	logic	[1:0]	w_field;

	// ------------------------------
	// FFFFh decode
	// ------------------------------
	// Register lives in page 3 of the primary slot
	assign w_hit	= sltsl && (cpu.addr == `MSX_EXP_SLOT_ADDR);
	assign w_rd_hit	= w_hit && !cpu.rd_n;

	always_ff @(posedge clk42m) begin
		if (!ff_reset_n) begin
			ff_ext <= 8'h00;					// Subslot 0 everywhere
		end
		else if (w_hit && !cpu.wr_n) begin
			ff_ext <= cpu.wdata;
		end
	end

	always_ff @(posedge clk42m) begin
		if (!ff_reset_n) begin
			ff_rd_hit_d <= 1'b0;
		end
		else begin
			ff_rd_hit_d <= w_rd_hit;
		end
	end

	// Inverted value, the usual expanded slot signature
	assign exp_rd = '{data: ~ff_ext, en: w_rd_hit && !ff_rd_hit_d};

	// ------------------------------
	// Subslot selects
	// ------------------------------
	assign w_field = ff_ext[{cpu.addr.mem.page, 1'b0} +: 2];

	always_comb begin
		for (int k = 0; k < 4; k++) begin
			sltsl_ext[k] = sltsl && (w_field == 2'(k));
		end
	end

endmodule

`default_nettype wire

// ==== rtl/primary_slot.sv ====
// Primary slot register at I/O port A8h and per-page primary slot selects
`default_nettype none
`include "msx_bus_defines.svh"

module primary_slot (
	input	logic					clk42m,
	input	logic					ff_reset_n,
	input	msx_bus_pkg::cpu_bus_t	cpu,
	output	msx_bus_pkg::rd_src_t	ppi_rd,		// Readback of port A8h
	output	logic	[3:0]			sltsl		// Primary select, one hot
);

	logic	[7:0]	ff_slot;		// Two bits per page, page 0 at bit 0
	logic			ff_rd_hit_d;	// Read hit in previous cycle
	logic			w_io_hit;
	logic			w_rd_hit;
	logic	[1:0]	w_field;		// Slot of the current page

	// ------------------------------
	// Port A8h decode
	// ------------------------------
	assign w_io_hit = !cpu.iorq_n && (cpu.addr.io.port == `MSX_PPI_PORT_A);
	assign w_rd_hit = w_io_hit && !cpu.rd_n;

	always_ff @(posedge clk42m) begin
		if (!ff_reset_n) begin
			ff_slot <= 8'h00;					// All pages in slot 0
		end
		else if (w_io_hit && !cpu.wr_n) begin
			ff_slot <= cpu.wdata;
		end
	end

	always_ff @(posedge clk42m) begin
		if (!ff_reset_n) begin
			ff_rd_hit_d <= 1'b0;
		end
		else begin
			ff_rd_hit_d <= w_rd_hit;
		end
	end

	// Strobe only on the first read cycle
	assign ppi_rd = '{data: ff_slot, en: w_rd_hit && !ff_rd_hit_d};

	// ------------------------------
	// Slot selects
	// ------------------------------
	assign w_field = ff_slot[{cpu.addr.mem.page, 1'b0} +: 2];

	always_comb begin
		for (int i = 0; i < 4; i++) begin
			sltsl[i] = !cpu.mreq_n && (w_field == 2'(i));	// Memory cycles only
		end
	end

endmodule

`default_nettype wire

// ==== rtl/cpu_clock_enable.sv ====
// CPU clock enable divider by six with SDRAM busy and freeze stall
`default_nettype none
`include "msx_bus_defines.svh"

module cpu_clock_enable (
	input	logic	clk42m,
	input	logic	ff_reset_n,		// Sync, active low
	input	logic	sdram_busy,		// Withholds the strobe
	input	logic	cpu_freeze,		// Stops and clears the divider
	output	logic	cpu_enable		// One cycle strobe
);

	logic	[2:0]	ff_cpu_div;		// Counts 0 to 5
	logic			w_div_last;

	// ------------------------------
	// Divider
	// ------------------------------
	assign w_div_last = (ff_cpu_div == `MSX_CPU_DIV_LAST);

	always_ff @(posedge clk42m) begin
		if (!ff_reset_n) begin
			ff_cpu_div <= 3'd0;
		end
		else if (cpu_freeze) begin
			ff_cpu_div <= 3'd0;					// Restart after freeze
		end
		else if (w_div_last) begin
			ff_cpu_div <= 3'd0;					// Wrap
		end
		else begin
			ff_cpu_div <= ff_cpu_div + 3'd1;
		end
	end

	// Busy masks the pulse, count keeps running
	// so the phase is kept across SDRAM stalls
	assign cpu_enable = w_div_last && !sdram_busy && !cpu_freeze;

endmodule

`default_nettype wire

// ==== rtl/msx_bus_pkg.sv ====
// Bus types: CPU address union, CPU bus, SPI write, slot selects, SDRAM request, read source
`default_nettype none
`include "msx_bus_defines.svh"

package msx_bus_pkg;

	// ------------------------------
	// CPU address, two decodes
	// ------------------------------
	typedef struct packed {
		logic	[1:0]	page;		// A15:A14
		logic			bank13;		// A13, low bank bit
		logic	[12:0]	offset;		// 8 KB offset
	} cpu_mem_addr_t;

	typedef struct packed {
		logic	[7:0]	high;		// Ignored on I/O cycles
		logic	[7:0]	port;
	} cpu_io_addr_t;

	// Same 16 bits, memory or I/O view
	typedef union packed {
		cpu_mem_addr_t	mem;
		cpu_io_addr_t	io;
	} cpu_addr_t;

	// ------------------------------
	// Bus bundles
	// ------------------------------
	typedef struct packed {
		cpu_addr_t		addr;
		logic	[7:0]	wdata;
		logic			mreq_n;
		logic			iorq_n;
		logic			rd_n;
		logic			wr_n;
	} cpu_bus_t;

	// SDRAM updater during freeze
	typedef struct packed {
		logic	[`MSX_SPI_AW-1:0]	address;
		logic	[7:0]				wdata;
		logic						req_n;	// Also the write strobe
	} spi_wr_t;

	typedef struct packed {
		logic			sltsl1;		// Primary slot 1
		logic			sltsl2;		// Primary slot 2
		logic	[3:0]	sub0;		// Slot 0-x
		logic	[3:0]	sub3;		// Slot 3-x
	} slot_sel_t;

	typedef struct packed {
		logic	[`MSX_SDRAM_AW-1:0]	address;
		logic	[7:0]				wdata;
		logic						mreq_n;
		logic						rd_n;
		logic						wr_n;
	} sdram_req_t;

	// One read data source
	typedef struct packed {
		logic	[7:0]	data;
		logic			en;		// Valid for one cycle
	} rd_src_t;

endpackage

`default_nettype wire

// ==== rtl/msx_bus_defines.svh ====
// I/O port, register address, divider, bus width and SDRAM bank code macros
`ifndef MSX_BUS_DEFINES_SVH
`define MSX_BUS_DEFINES_SVH

// ------------------------------
// Bus decode
// ------------------------------
`define MSX_PPI_PORT_A		8'hA8		// Primary slot register
`define MSX_EXP_SLOT_ADDR	16'hFFFF	// Secondary slot register

// CPU enable every sixth clk42m cycle
`define MSX_CPU_DIV_LAST	3'd5

// ------------------------------
// Widths
// ------------------------------
`define MSX_SDRAM_AW		23
`define MSX_SPI_AW			22			// One bit narrower than SDRAM

// ------------------------------
// SDRAM bank codes, address 22:13
// ------------------------------
// Full 8 KB granule codes
`define MSX_BANK_MAPPER		10'b100_0000_000	// Mapper RAM, slot 3-0
`define MSX_BANK_MEGA1M		10'b010_0000_000	// MegaROM 1 MB, slot 1
`define MSX_BANK_MEGA512K	10'b000_0100_000	// MegaROM 512 KB, slot 2
// Short codes, low bits from CPU address
`define MSX_BANK_LOGO_EXT	8'b000_0011_1		// + A14:A13
`define MSX_BANK_MUSIC		9'b000_0011_01		// + A13
`define MSX_BANK_IOT		9'b000_0011_00		// + A13
`define MSX_BANK_SUB_KANJI	8'b000_0010_1		// + A14:A13
`define MSX_BANK_MAIN		8'b000_0010_0		// + A14:A13
`define MSX_BANK_NEXTOR		7'b000_0000			// + A15:A13

`endif
